/* verilog/conv_post_pkg.sv */
package conv_post_pkg;

    //////////////////// widths
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int ACC_W    = 24;   // group sums wrap at this width
    localparam int BIAS_W   = 16;
    localparam int TAIL_W   = 16;
    localparam int RANK_W   = 5;
    localparam int MULT_A_W = 24;
    localparam int MULT_B_W = 17;   // one spare bit for the unsigned tail
    localparam int MULT_P_W = MULT_A_W + MULT_B_W;
    localparam int QPIXEL_W = 8;

    // cycles from a granted request to its product
    localparam int MULT_LATENCY = 2;

    //////////////////// vector types
    typedef logic        [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [BIAS_W-1:0]   bias_t;
    typedef logic        [TAIL_W-1:0]   tail_t;
    typedef logic        [RANK_W-1:0]   rank_t;
    typedef logic signed [MULT_A_W-1:0] mult_a_t;
    typedef logic signed [MULT_B_W-1:0] mult_b_t;
    typedef logic signed [MULT_P_W-1:0] mult_p_t;
    typedef logic signed [QPIXEL_W-1:0] qpixel_t;

    //////////////////// requantizer FSM
    typedef enum logic [1:0] {
        rq_idle,    // waiting for a sum, or holding a request
        rq_wait,    // granted, product in flight
        rq_out      // result register valid
    } requant_state_t;

endpackage

/* verilog/shared_multiplier.sv */
`timescale 1ns/1ps

module shared_multiplier (
    input  logic                   clk,
    input  logic                   reset,
    // accumulator side, always served
    input  logic                   mac_req,
    input  conv_post_pkg::mult_a_t mac_a,
    input  conv_post_pkg::mult_b_t mac_b,
    input  logic                   mac_tag_last,
    // requantizer side, served on idle cycles
    input  logic                   rq_req,
    input  conv_post_pkg::mult_a_t rq_a,
    input  conv_post_pkg::mult_b_t rq_b,
    output logic                   rq_grant,
    // results
    output conv_post_pkg::mult_p_t product,
    output logic                   prod_mac_valid,
    output logic                   prod_mac_last,
    output logic                   prod_rq_valid
);

    conv_post_pkg::mult_a_t a_q;
    conv_post_pkg::mult_b_t b_q;
    logic                   s1_mac_valid;
    logic                   s1_mac_last;
    logic                   s1_rq_valid;

    // fixed priority, accumulator first
    assign rq_grant = rq_req && !mac_req;

    //////////////////// stage 1 operands
    always_ff @(posedge clk) begin
        if (mac_req) begin
            a_q <= mac_a;
            b_q <= mac_b;
        end else begin
            a_q <= rq_a;
            b_q <= rq_b;
        end
    end

    //////////////////// stage 2 product
    always_ff @(posedge clk) begin
        product <= a_q * b_q; // full 41 bit signed product
    end

    // owner tags ride alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_mac_valid   <= 1'b0;
            s1_mac_last    <= 1'b0;
            s1_rq_valid    <= 1'b0;
            prod_mac_valid <= 1'b0;
            prod_mac_last  <= 1'b0;
            prod_rq_valid  <= 1'b0;
        end else begin
            s1_mac_valid   <= mac_req;
            s1_mac_last    <= mac_req && mac_tag_last;
            s1_rq_valid    <= rq_grant;
            prod_mac_valid <= s1_mac_valid;
            prod_mac_last  <= s1_mac_last;
            prod_rq_valid  <= s1_rq_valid;
        end
    end

    // a product belongs to one requester only
    product_single_owner: assert property (
        @(posedge clk) disable iff (reset)
        !(prod_mac_valid && prod_rq_valid)
    ) else $error("multiplier product claimed by both requesters");

endmodule

/* verilog/mac_accumulator.sv */
`timescale 1ns/1ps

module mac_accumulator (
    input  logic                   clk,
    input  logic                   reset,
    // term stream
    input  logic                   mac_valid,
    input  conv_post_pkg::pixel_t  pixel,
    input  conv_post_pkg::weight_t weight,
    input  logic                   mac_last,
    // multiplier request
    output logic                   mac_req,
    output conv_post_pkg::mult_a_t mac_a,
    output conv_post_pkg::mult_b_t mac_b,
    output logic                   mac_tag_last,
    // multiplier return
    input  conv_post_pkg::mult_p_t product,
    input  logic                   prod_mac_valid,
    input  logic                   prod_mac_last,
    // finished group sum
    output logic                   push,
    output conv_post_pkg::acc_t    push_sum
);

    conv_post_pkg::acc_t sum;
    conv_post_pkg::acc_t term;
    conv_post_pkg::acc_t next_sum;

    //////////////////// operand build
    assign mac_req      = mac_valid;
    assign mac_a        = {16'd0, pixel};            // pixel is unsigned
    assign mac_b        = {{9{weight[7]}}, weight};  // sign extend to 17 bits
    assign mac_tag_last = mac_last;

    //////////////////// accumulate
    assign term     = product[conv_post_pkg::ACC_W-1:0]; // wrap to sum width
    assign next_sum = sum + term;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum  <= '0;
            push <= 1'b0;
        end else begin
            push <= prod_mac_valid && prod_mac_last;
            if (prod_mac_valid) begin
                sum <= prod_mac_last ? '0 : next_sum; // restart on group end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_mac_valid && prod_mac_last) begin
            push_sum <= next_sum;
        end
    end

endmodule

/* verilog/sum_fifo.sv */
`timescale 1ns/1ps

module sum_fifo #(
    parameter  int DEPTH = 4,
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  conv_post_pkg::acc_t push_sum,
    input  logic                pop,
    output conv_post_pkg::acc_t head_sum,
    output logic                empty
);

    conv_post_pkg::acc_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign head_sum = mem[rd_ptr]; // first-word fall-through

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no back-pressure upstream, so overflow is a source error
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset) !(push && full)
    ) else $error("group sum pushed into full FIFO");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) !(pop && empty)
    ) else $error("pop from empty sum FIFO");

endmodule

/* verilog/requantizer.sv */
`timescale 1ns/1ps

module requantizer #(
    parameter  int NUM_CHANNELS = 4,
    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                   clk,
    input  logic                   reset,
    // coefficient table writes
    input  logic                   cfg_we,
    input  logic [CH_W-1:0]        cfg_channel,
    input  conv_post_pkg::bias_t   cfg_bias,
    input  conv_post_pkg::tail_t   cfg_tail,
    input  conv_post_pkg::rank_t   cfg_rank,
    // sum FIFO head
    input  logic                   empty,
    input  conv_post_pkg::acc_t    head_sum,
    output logic                   pop,
    // multiplier request and return
    output logic                   rq_req,
    output conv_post_pkg::mult_a_t rq_a,
    output conv_post_pkg::mult_b_t rq_b,
    input  logic                   rq_grant,
    input  conv_post_pkg::mult_p_t product,
    input  logic                   prod_rq_valid,
    // quantized pixel
    output logic                   out_valid,
    output conv_post_pkg::qpixel_t out_pixel
);

    localparam conv_post_pkg::mult_p_t QMAX = 127;
    localparam conv_post_pkg::mult_p_t QMIN = -128;

    conv_post_pkg::bias_t           bias_tab [NUM_CHANNELS];
    conv_post_pkg::tail_t           tail_tab [NUM_CHANNELS];
    conv_post_pkg::rank_t           rank_tab [NUM_CHANNELS];
    logic [CH_W-1:0]                ch_ptr;
    conv_post_pkg::requant_state_t  state;
    logic                           load_req;
    logic                           result_in;
    conv_post_pkg::acc_t            biased;
    conv_post_pkg::mult_p_t         shifted;

    function automatic conv_post_pkg::qpixel_t saturate(input conv_post_pkg::mult_p_t v);
        if (v > QMAX) return 8'h7f;
        if (v < QMIN) return 8'h80;
        return v[7:0];
    endfunction

    //////////////////// coefficient table
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                bias_tab[i] <= '0;
                tail_tab[i] <= '0;
                rank_tab[i] <= '0;
            end
        end else if (cfg_we) begin
            bias_tab[cfg_channel] <= cfg_bias;
            tail_tab[cfg_channel] <= cfg_tail;
            rank_tab[cfg_channel] <= cfg_rank;
        end
    end

    //////////////////// datapath
    assign biased    = head_sum + conv_post_pkg::acc_t'(bias_tab[ch_ptr]); // wraps at 24 bits
    assign shifted   = product >>> rank_tab[ch_ptr];  // arithmetic
    assign load_req  = !empty && !rq_req && (state != conv_post_pkg::rq_wait);
    assign result_in = (state == conv_post_pkg::rq_wait) && prod_rq_valid;
    assign pop       = rq_req && rq_grant; // sum leaves the FIFO once granted

    always_ff @(posedge clk) begin
        if (load_req) begin
            rq_a <= biased;
            rq_b <= {1'b0, tail_tab[ch_ptr]};
        end
        if (result_in) begin
            out_pixel <= saturate(shifted);
        end
    end

    //////////////////// FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= conv_post_pkg::rq_idle;
            rq_req    <= 1'b0;
            out_valid <= 1'b0;
            ch_ptr    <= '0;
        end else begin
            out_valid <= 1'b0;
            if (load_req) rq_req <= 1'b1; // request held until granted
            case (state)
                conv_post_pkg::rq_idle: begin
                    if (pop) begin
                        rq_req <= 1'b0;
                        state  <= conv_post_pkg::rq_wait;
                    end
                end
                conv_post_pkg::rq_wait: begin
                    if (prod_rq_valid) begin
                        out_valid <= 1'b1;
                        ch_ptr    <= (ch_ptr == CH_W'(NUM_CHANNELS - 1)) ? '0 : ch_ptr + 1'b1;
                        state     <= conv_post_pkg::rq_out;
                    end
                end
                conv_post_pkg::rq_out:  state <= conv_post_pkg::rq_idle;
                default:                state <= conv_post_pkg::rq_idle;
            endcase
        end
    end

    cfg_channel_in_range: assert property (
        @(posedge clk) disable iff (reset)
        cfg_we |-> (int'(cfg_channel) < NUM_CHANNELS)
    ) else $error("coefficient write to channel %0d out of range", cfg_channel);

    // granted request comes back from the shared bank at fixed latency
    grant_to_product: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> ##(conv_post_pkg::MULT_LATENCY) prod_rq_valid
    ) else $error("requantizer product missing after grant");

endmodule

/* verilog/conv_post_core.sv */
`timescale 1ns/1ps

module conv_post_core #(
    parameter  int NUM_CHANNELS   = 4,
    parameter  int SUM_FIFO_DEPTH = 4,
    localparam int CH_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1
) (
    input  logic                   clk,
    input  logic                   reset,
    // product terms
    input  logic                   mac_valid,
    input  conv_post_pkg::pixel_t  pixel,
    input  conv_post_pkg::weight_t weight,
    input  logic                   mac_last,
    // coefficient writes
    input  logic                   cfg_we,
    input  logic [CH_W-1:0]        cfg_channel,
    input  conv_post_pkg::bias_t   cfg_bias,
    input  conv_post_pkg::tail_t   cfg_tail,
    input  conv_post_pkg::rank_t   cfg_rank,
    // results
    output logic                   out_valid,
    output conv_post_pkg::qpixel_t out_pixel
);

    //////////////////// multiplier bank wiring
    logic                   mac_req;
    conv_post_pkg::mult_a_t mac_a;
    conv_post_pkg::mult_b_t mac_b;
    logic                   mac_tag_last;
    logic                   rq_req;
    conv_post_pkg::mult_a_t rq_a;
    conv_post_pkg::mult_b_t rq_b;
    logic                   rq_grant;
    conv_post_pkg::mult_p_t product;
    logic                   prod_mac_valid;
    logic                   prod_mac_last;
    logic                   prod_rq_valid;

    //////////////////// sum queue wiring
    logic                   push;
    conv_post_pkg::acc_t    push_sum;
    logic                   pop;
    conv_post_pkg::acc_t    head_sum;
    logic                   empty;

    mac_accumulator mac_accumulator_i (
        .clk, .reset,
        .mac_valid, .pixel, .weight, .mac_last,
        .mac_req, .mac_a, .mac_b, .mac_tag_last,
        .product, .prod_mac_valid, .prod_mac_last,
        .push, .push_sum
    );

    sum_fifo #(
        .DEPTH(SUM_FIFO_DEPTH)
    ) sum_fifo_i (
        .clk, .reset,
        .push, .push_sum,
        .pop, .head_sum, .empty
    );

    requantizer #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) requantizer_i (
        .clk, .reset,
        .cfg_we, .cfg_channel, .cfg_bias, .cfg_tail, .cfg_rank,
        .empty, .head_sum, .pop,
        .rq_req, .rq_a, .rq_b, .rq_grant,
        .product, .prod_rq_valid,
        .out_valid, .out_pixel
    );

    // one bank shared by both stages
    shared_multiplier shared_multiplier_i (
        .clk, .reset,
        .mac_req, .mac_a, .mac_b, .mac_tag_last,
        .rq_req, .rq_a, .rq_b, .rq_grant,
        .product, .prod_mac_valid, .prod_mac_last, .prod_rq_valid
    );

endmodule

/* bench/conv_post_tb.sv */
`timescale 1ns/1ps

module conv_post_tb;

    localparam int ROOM_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   mac_valid;
    conv_post_pkg::pixel_t  pixel;
    conv_post_pkg::weight_t weight;
    logic                   mac_last;
    logic                   cfg_we;
    logic [1:0]             cfg_channel;
    conv_post_pkg::bias_t   cfg_bias;
    conv_post_pkg::tail_t   cfg_tail;
    conv_post_pkg::rank_t   cfg_rank;
    logic                   out_valid;
    conv_post_pkg::qpixel_t out_pixel;

    // model of the coefficient table
    conv_post_pkg::bias_t   ref_bias [4];
    conv_post_pkg::tail_t   ref_tail [4];
    conv_post_pkg::rank_t   ref_rank [4];

    conv_post_pkg::pixel_t  grp_pix [16];  // terms of the group being sent
    conv_post_pkg::weight_t grp_wt [16];
    conv_post_pkg::qpixel_t expected_q [$];
    logic [15:0]            lfsr_state = 16'd49;
    int                     groups_sent = 0;
    int                     results_seen = 0;
    int                     lasts_seen = 0;
    int                     blocked_cycles = 0;
    bit                     saw_high = 0;
    bit                     saw_low = 0;

    conv_post_core conv_post_core_i (
        .clk, .reset,
        .mac_valid, .pixel, .weight, .mac_last,
        .cfg_we, .cfg_channel, .cfg_bias, .cfg_tail, .cfg_rank,
        .out_valid, .out_pixel
    );

    always #4 clk = ~clk;

    //////////////////// helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois taps 16,14,13,11
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // wrapped sum, bias, tail product, arithmetic shift, saturate
    function automatic conv_post_pkg::qpixel_t expected_pixel(
        input conv_post_pkg::pixel_t  pix [16],
        input conv_post_pkg::weight_t wt [16],
        input int                     n,
        input int                     ch
    );
        conv_post_pkg::acc_t acc;
        conv_post_pkg::acc_t biased;
        int                  term;
        longint              prod;
        longint              scaled;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            term = int'(pix[i]) * int'(wt[i]);
            acc  = acc + term[23:0];   // modulo 2^24
        end
        biased = acc + ref_bias[ch];
        prod   = longint'(biased) * longint'(ref_tail[ch]);
        scaled = prod >>> ref_rank[ch];
        if (scaled > 127) return 8'sd127;
        if (scaled < -128) return -8'sd128;
        return scaled[7:0];
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s got %0d, expected %0d", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic drive_term(input conv_post_pkg::pixel_t p, input conv_post_pkg::weight_t w,
                              input logic last);
        @(posedge clk);
        mac_valid <= 1'b1;
        pixel     <= p;
        weight    <= w;
        mac_last  <= last;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        mac_valid <= 1'b0;
        mac_last  <= 1'b0;
    endtask

    task automatic write_channel(input int ch, input int bias, input int tail, input int rank);
        @(posedge clk);
        cfg_we      <= 1'b1;
        cfg_channel <= 2'(ch);
        cfg_bias    <= conv_post_pkg::bias_t'(bias);
        cfg_tail    <= conv_post_pkg::tail_t'(tail);
        cfg_rank    <= conv_post_pkg::rank_t'(rank);
        ref_bias[ch] = conv_post_pkg::bias_t'(bias);
        ref_tail[ch] = conv_post_pkg::tail_t'(tail);
        ref_rank[ch] = conv_post_pkg::rank_t'(rank);
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    // expected value first, then the terms, then the mandatory idle cycle
    task automatic send_group(input int n, input bit with_gaps);
        expected_q.push_back(expected_pixel(grp_pix, grp_wt, n, groups_sent % 4));
        groups_sent++;
        for (int i = 0; i < n; i++) begin
            if (with_gaps && random_bits(2) == 0) drive_idle();
            drive_term(grp_pix[i], grp_wt[i], i == n - 1);
        end
        drive_idle();
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            grp_pix[i] = conv_post_pkg::pixel_t'(random_bits(8));
            grp_wt[i]  = conv_post_pkg::weight_t'(random_bits(8));
        end
    endtask

    // keeps at most four groups between input and output
    task automatic wait_for_room();
        int cycles;
        cycles = 0;
        while (expected_q.size() > 3) begin
            @(posedge clk);
            cycles++;
            if (cycles > ROOM_TIMEOUT) begin
                $display("timed out waiting for room before the next group");
                stop_with_failure();
            end
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                $display("timed out with %0d results still missing", expected_q.size());
                stop_with_failure();
            end
        end
    endtask

    //////////////////// compare
    always @(posedge clk) begin
        if (!reset) begin
            if (mac_valid && mac_last) lasts_seen++;
            if (conv_post_core_i.rq_req && mac_valid) blocked_cycles++; // rq held off
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid at %0t with no group outstanding", $time);
                    stop_with_failure();
                end else begin
                    check_value(int'(out_pixel), int'(expected_q.pop_front()), "out_pixel");
                    results_seen++;
                    if (out_pixel == 8'sd127) saw_high = 1;
                    if (out_pixel == -8'sd128) saw_low = 1;
                end
            end
        end
    end

    //////////////////// stimulus
    initial begin
        reset = 1'b1;
        mac_valid = 1'b0;
        pixel = '0;
        weight = '0;
        mac_last = 1'b0;
        cfg_we = 1'b0;
        cfg_channel = '0;
        cfg_bias = '0;
        cfg_tail = '0;
        cfg_rank = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // quiet period, any out_valid here is spurious
        repeat (12) drive_idle();
        write_channel(0, 0, 1, 8);
        write_channel(1, -500, 3, 10);
        write_channel(2, 1000, 7, 12);
        write_channel(3, -32768, 256, 16);

        // channel rotation over two full turns
        for (int g = 0; g < 8; g++) begin
            fill_random(4);
            wait_for_room();
            send_group(4, 0);
        end
        drain();

        // saturation, ranks 0 and 31
        write_channel(0, 100, 65535, 0);
        write_channel(1, -200, 300, 31);
        write_channel(2, -32768, 1000, 4);
        write_channel(3, 5, 1, 0);
        saw_high = 0;
        saw_low = 0;
        for (int g = 0; g < 8; g++) begin
            for (int i = 0; i < 4; i++) begin
                grp_pix[i] = 8'd255;
                grp_wt[i]  = (g % 2 == 0) ? 8'sd127 : -8'sd128;
            end
            wait_for_room();
            send_group(4, 0);
        end
        drain();
        check_value(saw_high, 1, "positive saturation seen");
        check_value(saw_low, 1, "negative saturation seen");

        // random lengths and gaps
        write_channel(0, 300, 40, 10);
        write_channel(1, -1200, 515, 14);
        write_channel(2, 0, 65535, 31);
        write_channel(3, 17, 3, 6);
        for (int g = 0; g < 40; g++) begin
            fill_random(16);
            wait_for_room();
            send_group(1 + random_bits(4), 1);
        end
        drain();
        blocked_cycles = 0;
        fill_random(16);
        send_group(1, 0);
        fill_random(16);
        send_group(16, 0);  // long group covers the pending request
        drain();
        // request up from cycle 5, long group busy through cycle 17
        check_value(blocked_cycles, 13, "cycles the requantizer waited");

        // bursts that fill the sum FIFO
        for (int b = 0; b < 3; b++) begin
            for (int g = 0; g < 7; g++) begin
                fill_random(1);
                send_group(1, 0);
            end
            drain();
        end
        check_value(results_seen, lasts_seen, "results per mac_last strobe");

        if (results_seen == groups_sent && expected_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d results for %0d groups", results_seen, groups_sent);
            stop_with_failure();
        end
    end

endmodule

/* tb.f */
verilog/conv_post_pkg.sv
verilog/shared_multiplier.sv
verilog/mac_accumulator.sv
verilog/sum_fifo.sv
verilog/requantizer.sv
verilog/conv_post_core.sv
bench/conv_post_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module conv_post_tb -o conv_post_sim

./obj_dir/conv_post_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
